/* bench/core_int_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module core_int_sva (
    input logic                clk,
    input logic                arst_n,
    input core_int_pkg::trap_t trap,
    input logic                global_enable
);

    int assert_errors = 0;

    // trap is a single cycle pulse
    trap_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) trap.valid |=> !trap.valid
    ) else begin
        assert_errors++;
        $error("trap.valid stayed high for two cycles");
    end

    trap_needs_enable: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(trap.valid) |-> $past(global_enable)
    ) else begin
        assert_errors++;
        $error("trap.valid rose without global enable in the prior cycle");
    end

    trap_quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> !trap.valid
    ) else begin
        assert_errors++;
        $error("trap.valid high while reset is asserted");
    end

endmodule

`default_nettype wire

/* bench/core_int_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_int_tb;
    import core_int_pkg::*;

    // names[] holds the name of each row at the same index
    typedef struct packed {
        logic      ext;
        logic      msip;
        reg_word_t mtimecmp;
        reg_word_t mie;
        reg_word_t mstatus;
        logic      expect_trap;
        reg_word_t expect_cause;
    } row_t;

    logic         clk;
    logic         arst_n;
    logic         int_ext;
    csr_write_t   csr_wr;
    clint_write_t clint_wr;
    retire_t      retire;
    trap_t        trap;
    reg_word_t    mepc_value;
    reg_word_t    mcause_value;

    row_t  rows [7];
    string names [7];
    int    value_errors;
    int    timeout_errors;

    core_int_top core_int_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .int_ext      (int_ext),
        .csr_wr       (csr_wr),
        .clint_wr     (clint_wr),
        .retire       (retire),
        .trap         (trap),
        .mepc_value   (mepc_value),
        .mcause_value (mcause_value)
    );

    bind interrupt_fsm core_int_sva core_int_sva_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .trap          (trap),
        .global_enable (global_enable)
    );

    always #20 clk = ~clk;

    // cause and epc only matter when a trap is expected
    task automatic check_trap(input string name, input trap_t expected, input trap_t actual);
        logic bad;
        bad = (actual.valid !== expected.valid);
        if (expected.valid && !bad) begin
            bad = (actual.cause !== expected.cause) || (actual.epc !== expected.epc);
        end
        if (bad) begin
            value_errors++;
            $display(
                "Error %s: expected valid=%0b cause=%h epc=%h, actual valid=%0b cause=%h epc=%h",
                name, expected.valid, expected.cause, expected.epc,
                actual.valid, actual.cause, actual.epc);
        end
    endtask

    task automatic check_word(input string name, input reg_word_t expected, input reg_word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic set_csr(input csr_addr_t addr, input reg_word_t data);
        @(posedge clk);
        csr_wr <= '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
        csr_wr <= '0;
    endtask

    task automatic load_clint(input clint_addr_t addr, input reg_word_t data);
        @(posedge clk);
        clint_wr <= '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
        clint_wr <= '0;
    endtask

    // mie 0x008 enables msi, 0x080 mti and 0x800 mei
    // mstatus 0x8 sets MIE
    task automatic fill_table();
        rows[0] = '{1'b1, 1'b0, 32'hffff_ffff, 32'h800, 32'h8, 1'b1, mcause_int_flag | 32'd11};
        names[0] = "ext_alone";
        rows[1] = '{1'b1, 1'b1, 32'hffff_ffff, 32'h808, 32'h8, 1'b1, mcause_int_flag | 32'd11};
        names[1] = "ext_over_software";
        rows[2] = '{1'b0, 1'b1, 32'hffff_ffff, 32'h008, 32'h8, 1'b1, mcause_int_flag | 32'd3};
        names[2] = "software_alone";
        rows[3] = '{1'b0, 1'b0, 32'd20, 32'h080, 32'h8, 1'b1, mcause_int_flag | 32'd7};
        names[3] = "timer_small_cmp";
        rows[4] = '{1'b1, 1'b1, 32'hffff_ffff, 32'h000, 32'h8, 1'b0, 32'd0};
        names[4] = "mie_bits_clear";
        rows[5] = '{1'b1, 1'b1, 32'hffff_ffff, 32'h808, 32'h0, 1'b0, 32'd0};
        names[5] = "global_mie_clear";
        rows[6] = '{1'b1, 1'b0, 32'hffff_ffff, 32'h800, 32'h8, 1'b1, mcause_int_flag | 32'd11};
        names[6] = "ext_reenabled";
    endtask

    task automatic run_row(input int idx);
        row_t      r;
        trap_t     expected;
        reg_word_t pc;
        reg_word_t prev_pc;
        logic      found;
        int        cycle;
        r       = rows[idx];
        found   = 1'b0;
        prev_pc = '0;
        expected = '0;
        load_clint(clint_mtime_addr, '0);
        load_clint(clint_mtimecmp_addr, r.mtimecmp);
        load_clint(clint_msip_addr, reg_word_t'(r.msip));
        set_csr(csr_mie_addr, r.mie);
        set_csr(csr_mstatus_addr, r.mstatus);
        @(posedge clk);
        int_ext <= r.ext;
        // trap shows up one cycle after the retirement that took it
        cycle = 0;
        while (!found && cycle < 64) begin
            @(posedge clk);
            pc = $urandom & 32'hffff_fffc;
            retire <= '{valid: 1'b1, pc: pc};
            @(negedge clk);
            if (trap.valid) begin
                found          = 1'b1;
                expected.valid = r.expect_trap;
                expected.cause = r.expect_cause;
                expected.epc   = prev_pc;
                check_trap(names[idx], expected, trap);
            end
            prev_pc = pc;
            cycle++;
        end
        @(posedge clk);
        retire <= '0;
        if (found && r.expect_trap) begin
            @(negedge clk);
            check_word({names[idx], " mepc"}, expected.epc, mepc_value);
            check_word({names[idx], " mcause"}, r.expect_cause, mcause_value);
            // requests still pending but MIE is now clear
            for (cycle = 0; cycle < 16; cycle++) begin
                @(posedge clk);
                retire <= '{valid: 1'b1, pc: $urandom & 32'hffff_fffc};
                @(negedge clk);
                if (trap.valid) begin
                    check_trap({names[idx], " second trap"}, '0, trap);
                end
            end
            @(posedge clk);
            retire <= '0;
        end else if (!found && r.expect_trap) begin
            timeout_errors++;
            $display("Test %s: no trap was seen within 64 retirements", names[idx]);
        end
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        int_ext        = 1'b0;
        csr_wr         = '0;
        clint_wr       = '0;
        retire         = '0;
        value_errors   = 0;
        timeout_errors = 0;
        void'($urandom(42));
        fill_table();

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_trap("reset", '0, trap);
        check_word("reset mepc", '0, mepc_value);
        check_word("reset mcause", '0, mcause_value);

        for (int i = 0; i < 7; i++) begin
            run_row(i);
        end

        $display("value errors: %0d, timeout errors: %0d, assertion errors: %0d",
                 value_errors, timeout_errors,
                 core_int_top_inst.interrupt_fsm_inst.core_int_sva_inst.assert_errors);
        if (value_errors == 0 && timeout_errors == 0 &&
            core_int_top_inst.interrupt_fsm_inst.core_int_sva_inst.assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/core_int_pkg.sv
rtl/clint_timer.sv
rtl/interrupt_fsm.sv
rtl/csrfile.sv
rtl/core_int_top.sv
bench/core_int_sva.sv
bench/core_int_tb.sv

/* rtl/clint_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  core_int_pkg::clint_write_t clint_wr,
    output logic                       timer_req,
    output logic                       software_req
);
    import core_int_pkg::*;

    reg_word_t mtime;
    reg_word_t mtimecmp;
    logic      msip;

    logic wr_msip;
    logic wr_mtimecmp;
    logic wr_mtime;

    // offset decode
    assign wr_msip     = clint_wr.valid && (clint_wr.addr == clint_msip_addr);
    assign wr_mtimecmp = clint_wr.valid && (clint_wr.addr == clint_mtimecmp_addr);
    assign wr_mtime    = clint_wr.valid && (clint_wr.addr == clint_mtime_addr);

    // free running unless a write loads it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else if (wr_mtime) begin
            mtime <= clint_wr.data;
        end else begin
            mtime <= mtime + reg_word_t'(1);
        end
    end

    // compare value starts at the top so no timer irq out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp <= clint_wr.data;
        end
    end

    // only bit 0 of msip is implemented
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            msip <= 1'b0;
        end else if (wr_msip) begin
            msip <= clint_wr.data[0];
        end
    end

    // request levels come straight from the registers
    assign timer_req    = (mtime >= mtimecmp);
    assign software_req = msip;

endmodule

`default_nettype wire

/* rtl/core_int_pkg.sv */
`default_nettype none

package core_int_pkg;

    // register data path
    localparam int reg_data_width = 32;
    typedef logic [reg_data_width - 1:0] reg_word_t;

    // machine csr addresses
    localparam int csr_addr_width = 12;
    typedef logic [csr_addr_width - 1:0] csr_addr_t;

    localparam csr_addr_t csr_mstatus_addr = 12'h300;
    localparam csr_addr_t csr_mie_addr     = 12'h304;
    localparam csr_addr_t csr_mepc_addr    = 12'h341;
    localparam csr_addr_t csr_mcause_addr  = 12'h342;

    // clint register offsets
    typedef logic [15:0] clint_addr_t;

    localparam clint_addr_t clint_msip_addr     = 16'h0000;
    localparam clint_addr_t clint_mtimecmp_addr = 16'h4000;
    localparam clint_addr_t clint_mtime_addr    = 16'hbff8;

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // mie/mip bit positions double as interrupt cause codes
    localparam int irq_msi_bit = 3;
    localparam int irq_mti_bit = 7;
    localparam int irq_mei_bit = 11;

    localparam reg_word_t mcause_int_flag = {1'b1, {(reg_data_width - 1){1'b0}}};

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        reg_word_t data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        clint_addr_t addr;
        reg_word_t   data;
    } clint_write_t;

    typedef struct packed {
        logic      valid;
        reg_word_t pc;
    } retire_t;

    typedef struct packed {
        logic ext;
        logic software;
        logic timer;
    } irq_req_t;

    typedef struct packed {
        logic      valid;
        reg_word_t cause;
        reg_word_t epc;
    } trap_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        armed = 2'd1,
        taken = 2'd2
    } int_state_t;

endpackage

`default_nettype wire

/* rtl/core_int_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_int_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       int_ext,
    input  core_int_pkg::csr_write_t   csr_wr,
    input  core_int_pkg::clint_write_t clint_wr,
    input  core_int_pkg::retire_t      retire,
    output core_int_pkg::trap_t        trap,
    output core_int_pkg::reg_word_t    mepc_value,
    output core_int_pkg::reg_word_t    mcause_value
);
    import core_int_pkg::*;

    // clint to csrfile
    logic     timer_req;
    logic     software_req;
    irq_req_t irq;

    // csrfile to interrupt_fsm
    reg_word_t mip_value;
    reg_word_t mie_value;
    logic      global_enable;

    assign irq = '{ext: int_ext, software: software_req, timer: timer_req};

    clint_timer clint_timer_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .clint_wr     (clint_wr),
        .timer_req    (timer_req),
        .software_req (software_req)
    );

    interrupt_fsm interrupt_fsm_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .retire        (retire),
        .mip_value     (mip_value),
        .mie_value     (mie_value),
        .global_enable (global_enable),
        .trap          (trap)
    );

    csrfile csrfile_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_wr        (csr_wr),
        .irq           (irq),
        .trap          (trap),
        .mip_value     (mip_value),
        .mie_value     (mie_value),
        .global_enable (global_enable),
        .mepc_value    (mepc_value),
        .mcause_value  (mcause_value)
    );

endmodule

`default_nettype wire

/* rtl/csrfile.sv */
`timescale 1ns/1ns
`default_nettype none

module csrfile (
    input  logic                     clk,
    input  logic                     arst_n,
    input  core_int_pkg::csr_write_t csr_wr,
    input  core_int_pkg::irq_req_t   irq,
    input  core_int_pkg::trap_t      trap,
    output core_int_pkg::reg_word_t  mip_value,
    output core_int_pkg::reg_word_t  mie_value,
    output logic                     global_enable,
    output core_int_pkg::reg_word_t  mepc_value,
    output core_int_pkg::reg_word_t  mcause_value
);
    import core_int_pkg::*;

    reg_word_t mstatus;
    reg_word_t mie;
    reg_word_t mepc;
    reg_word_t mcause;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mepc;
    logic wr_mcause;

    assign wr_mstatus = csr_wr.valid && (csr_wr.addr == csr_mstatus_addr);
    assign wr_mie     = csr_wr.valid && (csr_wr.addr == csr_mie_addr);
    assign wr_mepc    = csr_wr.valid && (csr_wr.addr == csr_mepc_addr);
    assign wr_mcause  = csr_wr.valid && (csr_wr.addr == csr_mcause_addr);

    // mip follows the request lines directly
    always_comb begin
        mip_value              = '0;
        mip_value[irq_msi_bit] = irq.software;
        mip_value[irq_mti_bit] = irq.timer;
        mip_value[irq_mei_bit] = irq.ext;
    end

    // only MIE and MPIE exist
    // trap entry stacks MIE into MPIE
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= '0;
        end else if (trap.valid) begin
            mstatus[mstatus_mpie_bit] <= mstatus[mstatus_mie_bit];
            mstatus[mstatus_mie_bit]  <= 1'b0;
        end else if (wr_mstatus) begin
            mstatus[mstatus_mie_bit]  <= csr_wr.data[mstatus_mie_bit];
            mstatus[mstatus_mpie_bit] <= csr_wr.data[mstatus_mpie_bit];
        end
    end

    // msie, mtie, meie
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mie <= '0;
        end else if (wr_mie) begin
            mie[irq_msi_bit] <= csr_wr.data[irq_msi_bit];
            mie[irq_mti_bit] <= csr_wr.data[irq_mti_bit];
            mie[irq_mei_bit] <= csr_wr.data[irq_mei_bit];
        end
    end

    // mepc is word aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mepc <= '0;
        end else if (trap.valid) begin
            mepc <= {trap.epc[reg_data_width - 1:2], 2'b00};
        end else if (wr_mepc) begin
            mepc <= {csr_wr.data[reg_data_width - 1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcause <= '0;
        end else if (trap.valid) begin
            mcause <= trap.cause;
        end else if (wr_mcause) begin
            mcause <= csr_wr.data;
        end
    end

    assign mie_value     = mie;
    assign global_enable = mstatus[mstatus_mie_bit];
    assign mepc_value    = mepc;
    assign mcause_value  = mcause;

endmodule

`default_nettype wire

/* rtl/interrupt_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module interrupt_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  core_int_pkg::retire_t   retire,
    input  core_int_pkg::reg_word_t mip_value,
    input  core_int_pkg::reg_word_t mie_value,
    input  logic                    global_enable,
    output core_int_pkg::trap_t     trap
);
    import core_int_pkg::*;

    int_state_t state;
    int_state_t state_next;

    reg_word_t pending;
    logic      irq_active;
    logic      take_irq;
    reg_word_t cause_code;

    logic      trap_valid;
    reg_word_t trap_cause;
    reg_word_t trap_epc;

    assign pending = mip_value & mie_value;

    assign irq_active = global_enable &&
                        (pending[irq_mei_bit] || pending[irq_msi_bit] || pending[irq_mti_bit]);

    // trap only at a retirement boundary while armed
    assign take_irq = (state == armed) && irq_active && retire.valid;

    // external beats software beats timer
    always_comb begin
        cause_code = '0;
        if (pending[irq_mei_bit]) begin
            cause_code = reg_word_t'(irq_mei_bit);
        end else if (pending[irq_msi_bit]) begin
            cause_code = reg_word_t'(irq_msi_bit);
        end else if (pending[irq_mti_bit]) begin
            cause_code = reg_word_t'(irq_mti_bit);
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            idle: begin
                if (irq_active) begin
                    state_next = armed;
                end
            end
            armed: begin
                if (!irq_active) begin
                    state_next = idle;
                end else if (retire.valid) begin
                    state_next = taken;
                end
            end
            taken: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            trap_valid <= 1'b0;
        end else begin
            state      <= state_next;
            trap_valid <= take_irq;
        end
    end

    // cause and epc are sampled at the retire cycle
    always_ff @(posedge clk) begin
        if (take_irq) begin
            trap_cause <= mcause_int_flag | cause_code;
            trap_epc   <= retire.pc;
        end
    end

    assign trap.valid = trap_valid;
    assign trap.cause = trap_cause;
    assign trap.epc   = trap_epc;

endmodule

`default_nettype wire
